// ==== db_params.svh ====
`ifndef DB_PARAMS_SVH
`define DB_PARAMS_SVH

// Entry and bus widths
`define DB_KEY_WID       8
`define DB_VALUE_WID     32
`define DB_WB_ADR_WID    4
`define DB_WB_DAT_WID    32

// Register byte offsets
`define DB_REG_CMD       4'h0
`define DB_REG_KEY       4'h4
`define DB_REG_VALUE     4'h8
`define DB_REG_STATUS    4'hC

// CMD register bits
`define DB_CMD_WR        0
`define DB_CMD_RD        1
`define DB_CMD_INIT      2
`define DB_CMD_INSERT    3

// STATUS register bits
`define DB_STS_BUSY      0
`define DB_STS_RD_VALID  1
`define DB_STS_INIT_DONE 2

`endif

// ==== db_pkg.sv ====
`include "db_params.svh"

package db_pkg;

    typedef logic [`DB_KEY_WID-1:0]    key_t;
    typedef logic [`DB_VALUE_WID-1:0]  value_t;
    typedef logic [`DB_WB_ADR_WID-1:0] wb_adr_t;
    typedef logic [`DB_WB_DAT_WID-1:0] wb_dat_t;

    // Write request, valid=0 deletes the key
    typedef struct packed {
        key_t   key;
        logic   valid;
        value_t value;
    } db_wr_req_t;

    // Read response, also the layout of one stored entry
    typedef struct packed {
        logic   valid;
        value_t value;
    } db_rd_resp_t;

    // Wishbone classic master signals
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    typedef enum logic {
        INIT_SWEEP,
        INIT_IDLE
    } init_state_t;

endpackage : db_pkg

// ==== db_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "db_params.svh"

module db_ctrl_regs (
    input  logic                clk,
    input  logic                srst,
    input  db_pkg::wb_req_t     i_wb,
    output db_pkg::wb_dat_t     o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_ctrl_wr_req,
    output db_pkg::db_wr_req_t  o_ctrl_wr,
    output logic                o_ctrl_rd_req,
    output db_pkg::key_t        o_ctrl_rd_key,
    input  logic                i_ctrl_gnt,
    input  logic                i_ctrl_rd_ack,
    input  db_pkg::db_rd_resp_t i_rd_resp,
    output logic                o_init_start,
    input  logic                i_init_done
);
    import db_pkg::*;

    key_t    key_reg;
    value_t  value_reg;
    logic    insert_reg;
    logic    pend_wr;
    logic    pend_rd;
    logic    rd_wait;
    logic    rd_valid;
    logic    busy;
    logic    wb_acc;
    logic    wb_wr;
    logic    cmd_wr;
    wb_dat_t rd_dat;

    // ------------------------------
    // Bus decode
    // ------------------------------
    // The ack cycle never starts a second access
    assign wb_acc = i_wb.cyc && i_wb.stb && !o_wb_ack;
    assign wb_wr  = wb_acc && i_wb.we;
    assign busy   = pend_wr || pend_rd;
    // Commands arriving while busy are dropped
    assign cmd_wr = wb_wr && (i_wb.adr == `DB_REG_CMD) && !busy;

    always_ff @(posedge clk) begin
        if (srst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= wb_acc;
        end
    end

    always_comb begin
        rd_dat = '0;
        case (i_wb.adr)
            `DB_REG_CMD: begin
                rd_dat[`DB_CMD_WR]     = pend_wr;
                rd_dat[`DB_CMD_RD]     = pend_rd;
                rd_dat[`DB_CMD_INSERT] = insert_reg;
            end
            `DB_REG_KEY:    rd_dat[`DB_KEY_WID-1:0] = key_reg;
            `DB_REG_VALUE:  rd_dat = value_reg;
            `DB_REG_STATUS: begin
                rd_dat[`DB_STS_BUSY]      = busy;
                rd_dat[`DB_STS_RD_VALID]  = rd_valid;
                rd_dat[`DB_STS_INIT_DONE] = i_init_done;
            end
            default:        rd_dat = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wb_acc) begin
            o_wb_dat <= rd_dat;
        end
    end

    // ------------------------------
    // Key and value registers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (wb_wr && (i_wb.adr == `DB_REG_KEY)) begin
            key_reg <= i_wb.dat[`DB_KEY_WID-1:0];
        end
        // Read result lands in VALUE
        if (i_ctrl_rd_ack) begin
            value_reg <= i_rd_resp.value;
        end else if (wb_wr && (i_wb.adr == `DB_REG_VALUE)) begin
            value_reg <= i_wb.dat;
        end
    end

    // ------------------------------
    // Pending command
    // ------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            pend_wr      <= 1'b0;
            pend_rd      <= 1'b0;
            rd_wait      <= 1'b0;
            rd_valid     <= 1'b0;
            insert_reg   <= 1'b0;
            o_init_start <= 1'b0;
        end else begin
            o_init_start <= cmd_wr && i_wb.dat[`DB_CMD_INIT];
            if (cmd_wr) begin
                // Write wins if both bits are set
                pend_wr    <= i_wb.dat[`DB_CMD_WR];
                pend_rd    <= i_wb.dat[`DB_CMD_RD] && !i_wb.dat[`DB_CMD_WR];
                insert_reg <= i_wb.dat[`DB_CMD_INSERT];
            end
            if (o_ctrl_wr_req && i_ctrl_gnt) begin
                pend_wr <= 1'b0;
            end
            if (o_ctrl_rd_req && i_ctrl_gnt) begin
                rd_wait <= 1'b1;
            end
            if (i_ctrl_rd_ack) begin
                pend_rd  <= 1'b0;
                rd_wait  <= 1'b0;
                rd_valid <= i_rd_resp.valid;
            end
        end
    end

    assign o_ctrl_wr_req   = pend_wr;
    assign o_ctrl_wr.key   = key_reg;
    assign o_ctrl_wr.valid = insert_reg;
    assign o_ctrl_wr.value = value_reg;
    // Request drops at the grant while busy waits for the result
    assign o_ctrl_rd_req   = pend_rd && !rd_wait;
    assign o_ctrl_rd_key   = key_reg;

    // Read results only come back for a granted read
    assert property (@(posedge clk) disable iff (srst)
        i_ctrl_rd_ack |-> rd_wait);

endmodule : db_ctrl_regs

// ==== db_prio_arb.sv ====
`timescale 1ns/1ps

module db_prio_arb (
    input  logic               clk,
    input  logic               srst,
    input  logic               i_init_done,
    input  logic               i_app_wr_req,
    input  db_pkg::db_wr_req_t i_app_wr,
    input  logic               i_app_rd_req,
    input  db_pkg::key_t       i_app_rd_key,
    input  logic               i_ctrl_wr_req,
    input  db_pkg::db_wr_req_t i_ctrl_wr,
    input  logic               i_ctrl_rd_req,
    input  db_pkg::key_t       i_ctrl_rd_key,
    output logic               o_app_wr_rdy,
    output logic               o_app_rd_rdy,
    output logic               o_ctrl_gnt,
    output logic               o_st_wr_en,
    output db_pkg::db_wr_req_t o_st_wr,
    output logic               o_st_rd_en,
    output db_pkg::key_t       o_st_rd_key,
    input  logic               i_st_rd_ack,
    output logic               o_app_rd_ack,
    output logic               o_ctrl_rd_ack
);
    logic app_wr_acc;
    logic app_rd_acc;
    logic ctrl_wr_gnt;
    logic ctrl_rd_gnt;
    logic rd_owner_ctrl;

    // Application only waits for the init sweep
    assign o_app_wr_rdy = i_init_done;
    assign o_app_rd_rdy = i_init_done;

    assign app_wr_acc  = i_app_wr_req && i_init_done;
    assign app_rd_acc  = i_app_rd_req && i_init_done;

    // Control gets a channel only when the application leaves it idle
    assign ctrl_wr_gnt = i_ctrl_wr_req && !i_app_wr_req && i_init_done;
    assign ctrl_rd_gnt = i_ctrl_rd_req && !i_app_rd_req && i_init_done;
    assign o_ctrl_gnt  = ctrl_wr_gnt || ctrl_rd_gnt;

    // ------------------------------
    // Store requests
    // ------------------------------
    assign o_st_wr_en  = app_wr_acc || ctrl_wr_gnt;
    assign o_st_wr     = i_app_wr_req ? i_app_wr : i_ctrl_wr;
    assign o_st_rd_en  = app_rd_acc || ctrl_rd_gnt;
    assign o_st_rd_key = i_app_rd_req ? i_app_rd_key : i_ctrl_rd_key;

    // Owner of the read that the store answers next cycle
    always_ff @(posedge clk) begin
        if (srst) begin
            rd_owner_ctrl <= 1'b0;
        end else begin
            rd_owner_ctrl <= ctrl_rd_gnt;
        end
    end

    assign o_app_rd_ack  = i_st_rd_ack && !rd_owner_ctrl;
    assign o_ctrl_rd_ack = i_st_rd_ack && rd_owner_ctrl;

    // A control grant puts the control request on the store port
    assert property (@(posedge clk) disable iff (srst)
        ctrl_wr_gnt |-> (o_st_wr == i_ctrl_wr));
    assert property (@(posedge clk) disable iff (srst)
        ctrl_rd_gnt |-> (o_st_rd_key == i_ctrl_rd_key));

    // Owner register relies on the store's fixed one-cycle read
    assert property (@(posedge clk) disable iff (srst)
        o_st_rd_en |=> i_st_rd_ack);

endmodule : db_prio_arb

// ==== db_store.sv ====
`timescale 1ns/1ps
`include "db_params.svh"

module db_store (
    input  logic                clk,
    input  logic                srst,
    input  logic                i_init_start,
    output logic                o_init_done,
    input  logic                i_wr_en,
    input  db_pkg::db_wr_req_t  i_wr,
    input  logic                i_rd_en,
    input  db_pkg::key_t        i_rd_key,
    output logic                o_rd_ack,
    output db_pkg::db_rd_resp_t o_rd
);
    import db_pkg::*;

    localparam int DEPTH = 1 << `DB_KEY_WID;

    logic        __srst;
    init_state_t state;
    key_t        sweep_key;
    db_rd_resp_t entry_wr;

    // One valid bit and value per key
    db_rd_resp_t mem [DEPTH];

    // Either reset or a software init restarts the sweep
    assign __srst = srst || i_init_start;

    // ------------------------------
    // Init sweep FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            state     <= INIT_SWEEP;
            sweep_key <= '0;
        end else begin
            case (state)
                INIT_SWEEP: begin
                    sweep_key <= sweep_key + key_t'(1);
                    if (sweep_key == key_t'(DEPTH - 1)) begin
                        state <= INIT_IDLE;
                    end
                end
                INIT_IDLE: begin
                    sweep_key <= '0;
                end
                default: begin
                    state <= INIT_SWEEP;
                end
            endcase
        end
    end

    assign o_init_done = (state == INIT_IDLE);

    // ------------------------------
    // Entry array
    // ------------------------------
    assign entry_wr.valid = i_wr.valid;
    assign entry_wr.value = i_wr.value;

    always_ff @(posedge clk) begin
        if (state == INIT_SWEEP) begin
            mem[sweep_key] <= '0;
        end else if (i_wr_en) begin
            mem[i_wr.key] <= entry_wr;
        end
    end

    // Read sees the contents from before a same-cycle write
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd <= mem[i_rd_key];
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            o_rd_ack <= 1'b0;
        end else begin
            o_rd_ack <= i_rd_en;
        end
    end

    // Arbiter must hold writes off while clearing
    assert property (@(posedge clk) disable iff (srst)
        (state == INIT_SWEEP) |-> !i_wr_en);

endmodule : db_store

// ==== db_core.sv ====
`timescale 1ns/1ps

module db_core (
    input  logic                clk,
    input  logic                srst,
    input  logic                i_app_wr_req,
    input  db_pkg::db_wr_req_t  i_app_wr,
    output logic                o_app_wr_rdy,
    input  logic                i_app_rd_req,
    input  db_pkg::key_t        i_app_rd_key,
    output logic                o_app_rd_rdy,
    output logic                o_app_rd_ack,
    output db_pkg::db_rd_resp_t o_app_rd,
    input  db_pkg::wb_req_t     i_wb,
    output db_pkg::wb_dat_t     o_wb_dat,
    output logic                o_wb_ack,
    output logic                o_init_done
);
    import db_pkg::*;

    // ------------------------------
    // Internal wires
    // ------------------------------
    logic        ctrl_wr_req;
    db_wr_req_t  ctrl_wr;
    logic        ctrl_rd_req;
    key_t        ctrl_rd_key;
    logic        ctrl_gnt;
    logic        ctrl_rd_ack;
    logic        init_start;
    logic        st_wr_en;
    db_wr_req_t  st_wr;
    logic        st_rd_en;
    key_t        st_rd_key;
    logic        st_rd_ack;
    db_rd_resp_t st_rd;

    db_ctrl_regs i_db_ctrl_regs (
        .clk           ( clk ),
        .srst          ( srst ),
        .i_wb          ( i_wb ),
        .o_wb_dat      ( o_wb_dat ),
        .o_wb_ack      ( o_wb_ack ),
        .o_ctrl_wr_req ( ctrl_wr_req ),
        .o_ctrl_wr     ( ctrl_wr ),
        .o_ctrl_rd_req ( ctrl_rd_req ),
        .o_ctrl_rd_key ( ctrl_rd_key ),
        .i_ctrl_gnt    ( ctrl_gnt ),
        .i_ctrl_rd_ack ( ctrl_rd_ack ),
        .i_rd_resp     ( st_rd ),
        .o_init_start  ( init_start ),
        .i_init_done   ( o_init_done )
    );

    // Application has strict priority on both channels
    db_prio_arb i_db_prio_arb (
        .clk           ( clk ),
        .srst          ( srst ),
        .i_init_done   ( o_init_done ),
        .i_app_wr_req  ( i_app_wr_req ),
        .i_app_wr      ( i_app_wr ),
        .i_app_rd_req  ( i_app_rd_req ),
        .i_app_rd_key  ( i_app_rd_key ),
        .i_ctrl_wr_req ( ctrl_wr_req ),
        .i_ctrl_wr     ( ctrl_wr ),
        .i_ctrl_rd_req ( ctrl_rd_req ),
        .i_ctrl_rd_key ( ctrl_rd_key ),
        .o_app_wr_rdy  ( o_app_wr_rdy ),
        .o_app_rd_rdy  ( o_app_rd_rdy ),
        .o_ctrl_gnt    ( ctrl_gnt ),
        .o_st_wr_en    ( st_wr_en ),
        .o_st_wr       ( st_wr ),
        .o_st_rd_en    ( st_rd_en ),
        .o_st_rd_key   ( st_rd_key ),
        .i_st_rd_ack   ( st_rd_ack ),
        .o_app_rd_ack  ( o_app_rd_ack ),
        .o_ctrl_rd_ack ( ctrl_rd_ack )
    );

    db_store i_db_store (
        .clk          ( clk ),
        .srst         ( srst ),
        .i_init_start ( init_start ),
        .o_init_done  ( o_init_done ),
        .i_wr_en      ( st_wr_en ),
        .i_wr         ( st_wr ),
        .i_rd_en      ( st_rd_en ),
        .i_rd_key     ( st_rd_key ),
        .o_rd_ack     ( st_rd_ack ),
        .o_rd         ( st_rd )
    );

    // Response data goes to both sides, only the ack is steered
    assign o_app_rd = st_rd;

endmodule : db_core

// ==== tb_db_core.sv ====
`timescale 1ns/1ps
`include "db_params.svh"

module tb_db_core;
    import db_pkg::*;

    logic        clk;
    logic        srst;
    logic        app_wr_req;
    db_wr_req_t  app_wr;
    logic        app_wr_rdy;
    logic        app_rd_req;
    key_t        app_rd_key;
    logic        app_rd_rdy;
    logic        app_rd_ack;
    db_rd_resp_t app_rd;
    wb_req_t     wb;
    wb_dat_t     wb_dat;
    logic        wb_ack;
    logic        init_done;

    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    key_t        key_a;
    key_t        key_b;
    key_t        key_c;
    value_t      val_a;
    value_t      val_b;
    value_t      val_c;

    db_core i_dut (
        .clk          ( clk ),
        .srst         ( srst ),
        .i_app_wr_req ( app_wr_req ),
        .i_app_wr     ( app_wr ),
        .o_app_wr_rdy ( app_wr_rdy ),
        .i_app_rd_req ( app_rd_req ),
        .i_app_rd_key ( app_rd_key ),
        .o_app_rd_rdy ( app_rd_rdy ),
        .o_app_rd_ack ( app_rd_ack ),
        .o_app_rd     ( app_rd ),
        .i_wb         ( wb ),
        .o_wb_dat     ( wb_dat ),
        .o_wb_ack     ( wb_ack ),
        .o_init_done  ( init_done )
    );

    always #10 clk = ~clk;

    // ------------------------------
    // Random numbers
    // ------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic key_t rand_key();
        logic [31:0] r;
        r = rand_bits(`DB_KEY_WID);
        return r[`DB_KEY_WID-1:0];
    endfunction

    function automatic db_rd_resp_t make_resp(input logic v, input value_t val);
        db_rd_resp_t r;
        r.valid = v;
        r.value = val;
        return r;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    // Value only matters for a valid entry
    task automatic check_resp(input string name, input db_rd_resp_t got,
                              input db_rd_resp_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.value !== exp.value)) begin
            errors++;
            $display("error: %s 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic expect_ack(input logic exp, input string what);
        if (app_rd_ack !== exp) begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors == err0) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errors - err0);
        end
    endtask

    // ------------------------------
    // Bus tasks
    // ------------------------------
    task automatic wb_access(input wb_adr_t adr, input logic we, input wb_dat_t dat,
                             output wb_dat_t rdat);
        int n;
        @(posedge clk);
        #1;
        wb.cyc = 1'b1;
        wb.stb = 1'b1;
        wb.we  = we;
        wb.adr = adr;
        wb.dat = dat;
        n = 0;
        @(posedge clk);
        #1;
        while (!wb_ack && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        rdat   = wb_dat;
        wb.cyc = 1'b0;
        wb.stb = 1'b0;
        wb.we  = 1'b0;
        if (!wb_ack) begin
            errors++;
            $display("timeout: no Wishbone ack for address 0x%h", adr);
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
        wb_dat_t unused;
        wb_access(adr, 1'b1, dat, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
        wb_access(adr, 1'b0, '0, dat);
    endtask

    task automatic wait_idle();
        wb_dat_t sts;
        int      n;
        n = 0;
        wb_read(`DB_REG_STATUS, sts);
        while (sts[`DB_STS_BUSY] && n < 50) begin
            wb_read(`DB_REG_STATUS, sts);
            n++;
        end
        if (sts[`DB_STS_BUSY]) begin
            errors++;
            $display("timeout: control command still busy");
        end
    endtask

    task automatic wait_init(input int limit);
        int n;
        n = 0;
        while (!init_done && n < limit) begin
            if (app_wr_rdy || app_rd_rdy) begin
                errors++;
                $display("application ready high during the init sweep");
            end
            @(posedge clk);
            #1;
            n++;
        end
        if (!init_done) begin
            errors++;
            $display("timeout: init done never rose");
        end
    endtask

    task automatic app_write(input key_t k, input logic v, input value_t val);
        int n;
        @(posedge clk);
        #1;
        app_wr_req   = 1'b1;
        app_wr.key   = k;
        app_wr.valid = v;
        app_wr.value = val;
        n = 0;
        while (!app_wr_rdy && n < 300) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!app_wr_rdy) begin
            errors++;
            $display("timeout: application write never accepted");
        end
        @(posedge clk);
        #1;
        app_wr_req = 1'b0;
    endtask

    // Second key is presented in the cycle the first one answers
    task automatic app_read_pair(input key_t k0, input key_t k1, input logic two,
                                 output db_rd_resp_t r0, output db_rd_resp_t r1);
        int n;
        @(posedge clk);
        #1;
        app_rd_req = 1'b1;
        app_rd_key = k0;
        n = 0;
        while (!app_rd_rdy && n < 300) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!app_rd_rdy) begin
            errors++;
            $display("timeout: application read never accepted");
        end
        @(posedge clk);
        #1;
        app_rd_key = k1;
        app_rd_req = two;
        r0 = app_rd;
        r1 = app_rd;
        expect_ack(1'b1, "read ack missing one cycle after accept");
        if (two) begin
            @(posedge clk);
            #1;
            app_rd_req = 1'b0;
            r1 = app_rd;
            expect_ack(1'b1, "second read ack missing one cycle after accept");
        end
        @(posedge clk);
        #1;
        expect_ack(1'b0, "read ack held longer than one cycle");
    endtask

    task automatic app_read(input key_t k, output db_rd_resp_t r);
        db_rd_resp_t unused;
        app_read_pair(k, k, 1'b0, r, unused);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic test_reset_init();
        int          err0;
        db_rd_resp_t r;
        err0 = errors;
        if (wb_ack || app_rd_ack || init_done) begin
            errors++;
            $display("ack or init done high right after reset");
        end
        wait_init(300);
        app_read(rand_key(), r);
        check_resp("o_app_rd", r, make_resp(1'b0, '0));
        report_test("reset and init sweep", err0);
    endtask

    task automatic test_app_write_read();
        int          err0;
        db_rd_resp_t r0;
        db_rd_resp_t r1;
        err0 = errors;
        key_a = rand_key();
        key_b = key_a ^ 8'h5a;
        val_a = rand_bits(32);
        val_b = rand_bits(32);
        app_write(key_a, 1'b1, val_a);
        app_write(key_b, 1'b1, val_b);
        app_read(key_a, r0);
        check_resp("o_app_rd", r0, make_resp(1'b1, val_a));
        app_read_pair(key_b, key_a, 1'b1, r0, r1);
        check_resp("o_app_rd", r0, make_resp(1'b1, val_b));
        check_resp("o_app_rd", r1, make_resp(1'b1, val_a));
        report_test("application write and read", err0);
    endtask

    task automatic test_ctrl_access();
        int          err0;
        db_rd_resp_t r;
        wb_dat_t     d;
        err0 = errors;
        key_c = key_a ^ 8'h33;
        val_c = rand_bits(32);
        wb_write(`DB_REG_KEY, wb_dat_t'(key_c));
        wb_write(`DB_REG_VALUE, val_c);
        wb_write(`DB_REG_CMD, (32'h1 << `DB_CMD_WR) | (32'h1 << `DB_CMD_INSERT));
        wait_idle();
        app_read(key_c, r);
        check_resp("o_app_rd", r, make_resp(1'b1, val_c));
        wb_write(`DB_REG_KEY, wb_dat_t'(key_b));
        wb_write(`DB_REG_CMD, 32'h1 << `DB_CMD_RD);
        wait_idle();
        wb_read(`DB_REG_STATUS, d);
        check_dat("STATUS", d, (32'h1 << `DB_STS_RD_VALID) | (32'h1 << `DB_STS_INIT_DONE));
        wb_read(`DB_REG_VALUE, d);
        check_dat("VALUE", d, val_b);
        report_test("control write and read", err0);
    endtask

    task automatic test_delete();
        int          err0;
        db_rd_resp_t r;
        err0 = errors;
        app_write(key_a, 1'b0, '0);
        app_read(key_a, r);
        check_resp("o_app_rd", r, make_resp(1'b0, '0));
        wb_write(`DB_REG_KEY, wb_dat_t'(key_c));
        wb_write(`DB_REG_CMD, 32'h1 << `DB_CMD_WR);
        wait_idle();
        app_read(key_c, r);
        check_resp("o_app_rd", r, make_resp(1'b0, '0));
        report_test("delete from both ports", err0);
    endtask

    task automatic test_ctrl_stall();
        int      err0;
        int      i;
        wb_dat_t d;
        err0 = errors;
        // Stale VALUE would hide a missing read result
        wb_write(`DB_REG_VALUE, ~val_b);
        wb_write(`DB_REG_KEY, wb_dat_t'(key_b));
        @(posedge clk);
        #1;
        app_rd_req = 1'b1;
        app_rd_key = key_a;
        wb_write(`DB_REG_CMD, 32'h1 << `DB_CMD_RD);
        for (i = 0; i < 4; i++) begin
            wb_read(`DB_REG_STATUS, d);
            if (!d[`DB_STS_BUSY]) begin
                errors++;
                $display("control read finished while the application held the channel");
            end
        end
        @(posedge clk);
        #1;
        app_rd_req = 1'b0;
        wait_idle();
        wb_read(`DB_REG_STATUS, d);
        check_dat("STATUS", d, (32'h1 << `DB_STS_RD_VALID) | (32'h1 << `DB_STS_INIT_DONE));
        wb_read(`DB_REG_VALUE, d);
        check_dat("VALUE", d, val_b);
        report_test("control read stalled by application", err0);
    endtask

    task automatic test_init_cmd();
        int          err0;
        int          n;
        wb_dat_t     d;
        db_rd_resp_t r;
        err0 = errors;
        app_write(key_a, 1'b1, val_a);
        wb_write(`DB_REG_CMD, 32'h1 << `DB_CMD_INIT);
        n = 0;
        while (init_done && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (init_done) begin
            errors++;
            $display("init command did not start the sweep");
        end
        wait_init(300);
        wb_read(`DB_REG_STATUS, d);
        check_dat("STATUS init done", d & (32'h1 << `DB_STS_INIT_DONE),
                  32'h1 << `DB_STS_INIT_DONE);
        app_read(key_a, r);
        check_resp("o_app_rd", r, make_resp(1'b0, '0));
        app_read(key_b, r);
        check_resp("o_app_rd", r, make_resp(1'b0, '0));
        report_test("init command", err0);
    endtask

    initial begin
        clk          = 1'b0;
        srst         = 1'b1;
        app_wr_req   = 1'b0;
        app_wr       = '0;
        app_rd_req   = 1'b0;
        app_rd_key   = '0;
        wb           = '0;
        lfsr         = 32'h22e3020b;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #1;
        srst = 1'b0;
        test_reset_init();
        test_app_write_read();
        test_ctrl_access();
        test_delete();
        test_ctrl_stall();
        test_init_cmd();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_db_core

// ==== all.f ====
+incdir+.
db_pkg.sv
db_ctrl_regs.sv
db_prio_arb.sv
db_store.sv
db_core.sv
tb_db_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_db_core -f all.f
out=$(./obj_dir/Vtb_db_core)
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
